//--- filelist.f
source/systolic_cfg_pkg.sv
source/systolic_ctrl_pkg.sv
source/mac_pe.sv
source/pe_array.sv
source/array_controller.sv
source/proxy_tracker.sv
source/ws_systolic_top.sv
tb/tb_ws_systolic.sv

//--- Bender.yml
package:
  name: ws_systolic

sources:
  - files:
      - source/systolic_cfg_pkg.sv
      - source/systolic_ctrl_pkg.sv
      - source/mac_pe.sv
      - source/pe_array.sv
      - source/array_controller.sv
      - source/proxy_tracker.sv
      - source/ws_systolic_top.sv
  - target: test
    files:
      - tb/tb_ws_systolic.sv

//--- tb/tb_ws_systolic.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ws_systolic;

    localparam int ROWS         = systolic_cfg_pkg::DEFAULT_ROWS;
    localparam int COLS         = systolic_cfg_pkg::DEFAULT_COLS;
    localparam int WORD_SIZE    = systolic_cfg_pkg::DEFAULT_WORD_SIZE;
    localparam int IDX_W        = (ROWS > 1) ? $clog2(ROWS) : 1;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_VEC      = 12;

    // reset, idle matmul, two loads with proxy checks, one single and two streamed runs
    localparam int RUN_CYCLES = RESET_CYCLES + 8 + 2 * (ROWS + 2) +
                                3 * (ROWS + COLS + 1) + 2 * NUM_VEC + 1;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 50;

    logic                              clk;
    logic                              rst;
    systolic_ctrl_pkg::array_op_e      op;
    logic [COLS*WORD_SIZE-1:0]         top_in_bus;
    logic [ROWS*WORD_SIZE-1:0]         left_in_bus;
    logic [COLS*WORD_SIZE-1:0]         bottom_out_bus;
    logic [ROWS*WORD_SIZE-1:0]         right_out_bus;
    logic [COLS*IDX_W-1:0]             proxy_idx_bus;
    logic [COLS*WORD_SIZE-1:0]         proxy_weight_bus;
    logic                              proxy_valid;

    // wt[r][c] is the weight that ends up in row r of column c
    logic [WORD_SIZE-1:0] wt [ROWS][COLS];
    logic [WORD_SIZE-1:0] act_vec [NUM_VEC][ROWS];
    integer               seed;

    ws_systolic_top #(
        .ROWS      (ROWS),
        .COLS      (COLS),
        .WORD_SIZE (WORD_SIZE)
    ) u_ws_systolic_top (
        .clk              (clk),
        .rst              (rst),
        .op               (op),
        .top_in_bus       (top_in_bus),
        .left_in_bus      (left_in_bus),
        .bottom_out_bus   (bottom_out_bus),
        .right_out_bus    (right_out_bus),
        .proxy_idx_bus    (proxy_idx_bus),
        .proxy_weight_bus (proxy_weight_bus),
        .proxy_valid      (proxy_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run went past its cycle budget");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    task automatic compare_word(input string name, input logic [WORD_SIZE-1:0] got,
                                input logic [WORD_SIZE-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic compare_idx(input string name, input logic [IDX_W-1:0] got,
                               input logic [IDX_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "index mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "flag mismatch");
        end
    endtask

    // reference dot product, wraps at WORD_SIZE bits
    function automatic logic [WORD_SIZE-1:0] dot_product(input int v, input int c);
        logic [WORD_SIZE-1:0] acc;
        acc = '0;
        for (int r = 0; r < ROWS; r++) begin
            acc = acc + act_vec[v][r] * wt[r][c];
        end
        return acc;
    endfunction

    // weights arrive top row last, so walk rows from ROWS-1 down with a strict compare
    task automatic column_minimum(input int c, output logic [IDX_W-1:0] min_row,
                                  output logic [WORD_SIZE-1:0] min_w);
        min_row = IDX_W'(ROWS - 1);
        min_w   = wt[ROWS-1][c];
        for (int r = ROWS - 2; r >= 0; r--) begin
            if (wt[r][c] < min_w) begin
                min_w   = wt[r][c];
                min_row = IDX_W'(r);
            end
        end
    endtask

    task automatic fill_weights(input int equal_col);
        logic [WORD_SIZE-1:0] same;
        same = WORD_SIZE'($random(seed));
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                wt[r][c] = (c == equal_col) ? same : WORD_SIZE'($random(seed));
            end
        end
    endtask

    task automatic fill_activations(input int nvec);
        for (int v = 0; v < nvec; v++) begin
            for (int r = 0; r < ROWS; r++) begin
                act_vec[v][r] = WORD_SIZE'($random(seed));
            end
        end
    endtask

    task automatic check_idle_outputs();
        for (int c = 0; c < COLS; c++) begin
            compare_word($sformatf("bottom_out_bus[%0d]", c),
                         bottom_out_bus[c*WORD_SIZE +: WORD_SIZE], '0);
            compare_word($sformatf("proxy_weight_bus[%0d]", c),
                         proxy_weight_bus[c*WORD_SIZE +: WORD_SIZE], '0);
            compare_idx($sformatf("proxy_idx_bus[%0d]", c),
                        proxy_idx_bus[c*IDX_W +: IDX_W], '0);
        end
        for (int r = 0; r < ROWS; r++) begin
            compare_word($sformatf("right_out_bus[%0d]", r),
                         right_out_bus[r*WORD_SIZE +: WORD_SIZE], '0);
        end
        compare_flag("proxy_valid", proxy_valid, 1'b0);
    endtask

    // matmul in st_empty must not move anything
    task automatic matmul_while_empty();
        for (int t = 0; t < 4; t++) begin
            @(negedge clk);
            op = systolic_ctrl_pkg::op_matmul;
            for (int r = 0; r < ROWS; r++) begin
                left_in_bus[r*WORD_SIZE +: WORD_SIZE] = WORD_SIZE'($random(seed));
            end
        end
        @(negedge clk);
        op          = systolic_ctrl_pkg::op_idle;
        left_in_bus = '0;
        @(negedge clk);
        check_idle_outputs();
    endtask

    // op leads the top edge words by one cycle
    task automatic load_weights();
        logic [COLS*WORD_SIZE-1:0] row_word;
        for (int k = 0; k <= ROWS; k++) begin
            @(negedge clk);
            if (k > 0) begin
                compare_flag("proxy_valid", proxy_valid, 1'b0);
            end
            row_word = '0;
            if (k > 0) begin
                for (int c = 0; c < COLS; c++) begin
                    row_word[c*WORD_SIZE +: WORD_SIZE] = wt[ROWS-k][c];
                end
            end
            top_in_bus = row_word;
            if (k < ROWS) begin
                op = systolic_ctrl_pkg::op_load;
            end else begin
                op = systolic_ctrl_pkg::op_idle;
            end
        end
    endtask

    task automatic check_proxy();
        logic [IDX_W-1:0]     exp_row;
        logic [WORD_SIZE-1:0] exp_w;
        @(negedge clk);
        top_in_bus = '0;
        compare_flag("proxy_valid", proxy_valid, 1'b1);
        for (int c = 0; c < COLS; c++) begin
            column_minimum(c, exp_row, exp_w);
            compare_idx($sformatf("proxy_idx_bus[%0d]", c),
                        proxy_idx_bus[c*IDX_W +: IDX_W], exp_row);
            compare_word($sformatf("proxy_weight_bus[%0d]", c),
                         proxy_weight_bus[c*WORD_SIZE +: WORD_SIZE], exp_w);
        end
    endtask

    // vector v enters row r at cycle v+r+1, one vector per cycle
    task automatic stream_vectors(input int nvec);
        logic [ROWS*WORD_SIZE-1:0] left_word;
        int                        v;
        for (int t = 0; t < nvec + ROWS + COLS; t++) begin
            @(negedge clk);
            for (int c = 0; c < COLS; c++) begin
                v = t - ROWS - c - 1;
                if (v >= 0 && v < nvec) begin
                    compare_word($sformatf("bottom_out_bus[%0d] vector %0d", c, v),
                                 bottom_out_bus[c*WORD_SIZE +: WORD_SIZE], dot_product(v, c));
                end
            end
            for (int r = 0; r < ROWS; r++) begin
                v = t - r - COLS - 1;
                if (v >= 0 && v < nvec) begin
                    compare_word($sformatf("right_out_bus[%0d] vector %0d", r, v),
                                 right_out_bus[r*WORD_SIZE +: WORD_SIZE], act_vec[v][r]);
                end
            end
            left_word = '0;
            for (int r = 0; r < ROWS; r++) begin
                v = t - r - 1;
                if (v >= 0 && v < nvec) begin
                    left_word[r*WORD_SIZE +: WORD_SIZE] = act_vec[v][r];
                end
            end
            left_in_bus = left_word;
            op          = systolic_ctrl_pkg::op_matmul;
        end
        @(negedge clk);
        op          = systolic_ctrl_pkg::op_idle;
        left_in_bus = '0;
    endtask

    initial begin
        seed        = 32'h12cf;
        rst         = 1'b1;
        op          = systolic_ctrl_pkg::op_idle;
        top_in_bus  = '0;
        left_in_bus = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_idle_outputs();
        matmul_while_empty();

        // column 1 holds one value in every row
        fill_weights(1);
        load_weights();
        check_proxy();
        fill_activations(1);
        stream_vectors(1);
        fill_activations(NUM_VEC);
        stream_vectors(NUM_VEC);

        // reload from st_ready
        fill_weights(-1);
        load_weights();
        check_proxy();
        fill_activations(NUM_VEC);
        stream_vectors(NUM_VEC);

        $display("Finished with no errors");
        $finish;
    end

endmodule : tb_ws_systolic

`default_nettype wire

//--- source/ws_systolic_top.sv
`timescale 1ns/100ps
`default_nettype none

module ws_systolic_top #(
    parameter int ROWS      = systolic_cfg_pkg::DEFAULT_ROWS,
    parameter int COLS      = systolic_cfg_pkg::DEFAULT_COLS,
    parameter int WORD_SIZE = systolic_cfg_pkg::DEFAULT_WORD_SIZE,
    localparam int IDX_W    = (ROWS > 1) ? $clog2(ROWS) : 1
) (
    input  wire                               clk,
    input  wire                               rst,
    input  wire systolic_ctrl_pkg::array_op_e op,
    input  wire [COLS*WORD_SIZE-1:0]          top_in_bus,
    input  wire [ROWS*WORD_SIZE-1:0]          left_in_bus,
    output logic [COLS*WORD_SIZE-1:0]         bottom_out_bus,
    output logic [ROWS*WORD_SIZE-1:0]         right_out_bus,
    output logic [COLS*IDX_W-1:0]             proxy_idx_bus,
    output logic [COLS*WORD_SIZE-1:0]         proxy_weight_bus,
    output logic                              proxy_valid
);

    systolic_ctrl_pkg::pe_ctrl_t    pe_ctrl;
    systolic_ctrl_pkg::track_ctrl_t track_ctrl;

    // registered strobes, one cycle after op
    array_controller #(
        .ROWS(ROWS)
    ) u_array_controller (
        .clk         (clk),
        .rst         (rst),
        .op          (op),
        .pe_ctrl     (pe_ctrl),
        .track_ctrl  (track_ctrl),
        .proxy_valid (proxy_valid)
    );

    pe_array #(
        .ROWS      (ROWS),
        .COLS      (COLS),
        .WORD_SIZE (WORD_SIZE)
    ) u_pe_array (
        .clk            (clk),
        .rst            (rst),
        .pe_ctrl        (pe_ctrl),
        .top_in_bus     (top_in_bus),
        .left_in_bus    (left_in_bus),
        .bottom_out_bus (bottom_out_bus),
        .right_out_bus  (right_out_bus)
    );

    // watches the same top edge words that the array shifts in
    proxy_tracker #(
        .ROWS      (ROWS),
        .COLS      (COLS),
        .WORD_SIZE (WORD_SIZE)
    ) u_proxy_tracker (
        .clk              (clk),
        .rst              (rst),
        .track_ctrl       (track_ctrl),
        .top_in_bus       (top_in_bus),
        .proxy_idx_bus    (proxy_idx_bus),
        .proxy_weight_bus (proxy_weight_bus)
    );

endmodule : ws_systolic_top

`default_nettype wire

//--- source/proxy_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module proxy_tracker #(
    parameter int ROWS      = 4,
    parameter int COLS      = 4,
    parameter int WORD_SIZE = 16,
    localparam int IDX_W    = (ROWS > 1) ? $clog2(ROWS) : 1
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire systolic_ctrl_pkg::track_ctrl_t track_ctrl,
    input  wire [COLS*WORD_SIZE-1:0]           top_in_bus,
    output logic [COLS*IDX_W-1:0]              proxy_idx_bus,
    output logic [COLS*WORD_SIZE-1:0]          proxy_weight_bus
);

    logic [IDX_W-1:0] row_now;

    // only the low bits of the shared row counter are meaningful here
    assign row_now = track_ctrl.row_idx[IDX_W-1:0];

    genvar c;

    generate
        for (c = 0; c < COLS; c = c + 1) begin : col_gen
            logic [WORD_SIZE-1:0] col_weight;
            logic [WORD_SIZE-1:0] min_weight_q;
            logic [IDX_W-1:0]     min_idx_q;
            logic                 take;

            assign col_weight = top_in_bus[c*WORD_SIZE +: WORD_SIZE];

            // strict compare, so a tie keeps the earlier (higher) row
            assign take = track_ctrl.track_en &&
                          (track_ctrl.first_weight || (col_weight < min_weight_q));

            always_ff @(posedge clk) begin
                if (rst) begin
                    min_weight_q <= '0;
                    min_idx_q    <= '0;
                end else if (take) begin
                    min_weight_q <= col_weight;
                    min_idx_q    <= row_now;
                end
            end

            assign proxy_weight_bus[c*WORD_SIZE +: WORD_SIZE] = min_weight_q;
            assign proxy_idx_bus[c*IDX_W +: IDX_W]            = min_idx_q;
        end
    endgenerate

    // the controller must never point past the last row
    row_idx_in_range: assert property (
        @(posedge clk) disable iff (rst)
        track_ctrl.track_en |-> (int'(track_ctrl.row_idx) < ROWS)
    ) else $error("row_idx %0d out of range", track_ctrl.row_idx);

endmodule : proxy_tracker

`default_nettype wire

//--- source/array_controller.sv
`timescale 1ns/100ps
`default_nettype none

module array_controller #(
    parameter int ROWS = 4
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire systolic_ctrl_pkg::array_op_e op,
    output systolic_ctrl_pkg::pe_ctrl_t     pe_ctrl,
    output systolic_ctrl_pkg::track_ctrl_t  track_ctrl,
    output logic                            proxy_valid
);

    // row that receives the first weight of a load
    localparam logic [7:0] LAST_ROW = 8'(ROWS - 1);

    systolic_ctrl_pkg::ctrl_state_e state;

    logic start_load;
    logic load_more;

    assign start_load = (op == systolic_ctrl_pkg::op_load) &&
                        (state != systolic_ctrl_pkg::st_loading);
    assign load_more  = (state == systolic_ctrl_pkg::st_loading) &&
                        (track_ctrl.row_idx != 8'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= systolic_ctrl_pkg::st_empty;
            pe_ctrl     <= '0;
            track_ctrl  <= '0;
            proxy_valid <= 1'b0;
        end else begin
            // strobes are single-cycle unless renewed below
            pe_ctrl                 <= '0;
            track_ctrl.track_en     <= 1'b0;
            track_ctrl.first_weight <= 1'b0;

            if (start_load) begin
                state                   <= systolic_ctrl_pkg::st_loading;
                pe_ctrl.load_en         <= 1'b1;
                track_ctrl.track_en     <= 1'b1;
                track_ctrl.first_weight <= 1'b1;
                track_ctrl.row_idx      <= LAST_ROW;
                proxy_valid             <= 1'b0;
            end else if (load_more) begin
                pe_ctrl.load_en     <= 1'b1;
                track_ctrl.track_en <= 1'b1;
                track_ctrl.row_idx  <= track_ctrl.row_idx - 8'd1;
            end else if (state == systolic_ctrl_pkg::st_loading) begin
                // row 0 weight captured at this edge
                state       <= systolic_ctrl_pkg::st_ready;
                proxy_valid <= 1'b1;
            end else if ((state == systolic_ctrl_pkg::st_ready) &&
                         (op == systolic_ctrl_pkg::op_matmul)) begin
                pe_ctrl.mac_en <= 1'b1;
            end
        end
    end

    // a load may not be cut short by another command
    load_op_held: assert property (
        @(posedge clk) disable iff (rst)
        load_more |-> (op == systolic_ctrl_pkg::op_load)
    ) else $error("op left op_load in the middle of a weight load");

    // cells must never shift weights and accumulate in the same cycle
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(pe_ctrl.load_en && pe_ctrl.mac_en)
    ) else $error("load_en and mac_en both high");

endmodule : array_controller

`default_nettype wire

//--- source/pe_array.sv
`timescale 1ns/100ps
`default_nettype none

module pe_array #(
    parameter int ROWS      = 4,
    parameter int COLS      = 4,
    parameter int WORD_SIZE = 16
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire systolic_ctrl_pkg::pe_ctrl_t pe_ctrl,
    input  wire [COLS*WORD_SIZE-1:0]        top_in_bus,
    input  wire [ROWS*WORD_SIZE-1:0]        left_in_bus,
    output logic [COLS*WORD_SIZE-1:0]       bottom_out_bus,
    output logic [ROWS*WORD_SIZE-1:0]       right_out_bus
);

    // hor[r][c] feeds the left of cell (r,c), hor[r][COLS] leaves the right edge
    wire [WORD_SIZE-1:0] hor [ROWS][COLS+1];
    // ver[r][c] feeds the top of cell (r,c), ver[ROWS][c] leaves the bottom edge
    wire [WORD_SIZE-1:0] ver [ROWS+1][COLS];

    genvar r, c;

    generate
        for (r = 0; r < ROWS; r = r + 1) begin : row_edge_gen
            assign hor[r][0] = left_in_bus[r*WORD_SIZE +: WORD_SIZE];
            assign right_out_bus[r*WORD_SIZE +: WORD_SIZE] = hor[r][COLS];
        end

        for (c = 0; c < COLS; c = c + 1) begin : col_edge_gen
            assign ver[0][c] = top_in_bus[c*WORD_SIZE +: WORD_SIZE];
            assign bottom_out_bus[c*WORD_SIZE +: WORD_SIZE] = ver[ROWS][c];
        end

        // same wiring rule for corner, edge and interior cells
        for (r = 0; r < ROWS; r = r + 1) begin : mac_row_gen
            for (c = 0; c < COLS; c = c + 1) begin : mac_col_gen
                mac_pe #(
                    .WORD_SIZE(WORD_SIZE)
                ) u_mac_pe (
                    .clk        (clk),
                    .rst        (rst),
                    .pe_ctrl    (pe_ctrl),
                    .left_in    (hor[r][c]),
                    .top_in     (ver[r][c]),
                    .right_out  (hor[r][c+1]),
                    .bottom_out (ver[r+1][c])
                );
            end
        end
    endgenerate

endmodule : pe_array

`default_nettype wire

//--- source/mac_pe.sv
`timescale 1ns/100ps
`default_nettype none

module mac_pe #(
    parameter int WORD_SIZE = 16
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire systolic_ctrl_pkg::pe_ctrl_t pe_ctrl,
    input  wire [WORD_SIZE-1:0]            left_in,
    input  wire [WORD_SIZE-1:0]            top_in,
    output logic [WORD_SIZE-1:0]           right_out,
    output logic [WORD_SIZE-1:0]           bottom_out
);

    logic [WORD_SIZE-1:0] weight_q;
    logic [WORD_SIZE-1:0] act_q;
    logic [WORD_SIZE-1:0] psum_q;
    logic [WORD_SIZE-1:0] mac_result;

    // wraps modulo 2**WORD_SIZE
    assign mac_result = top_in + left_in * weight_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            weight_q <= '0;
            act_q    <= '0;
            psum_q   <= '0;
        end else if (pe_ctrl.load_en) begin
            // weight also goes out the bottom so the column acts as a shift chain
            weight_q <= top_in;
            psum_q   <= top_in;
        end else if (pe_ctrl.mac_en) begin
            act_q  <= left_in;
            psum_q <= mac_result;
        end
    end

    assign right_out  = act_q;
    assign bottom_out = psum_q;

endmodule : mac_pe

`default_nettype wire

//--- source/systolic_ctrl_pkg.sv
`default_nettype none

// command, state and control struct definitions for the array
package systolic_ctrl_pkg;

    // top level command, held as a plain level
    typedef enum logic [1:0] {
        op_idle   = 2'd0,
        op_load   = 2'd1,
        op_matmul = 2'd2
    } array_op_e;

    // phase of the array
    typedef enum logic [1:0] {
        st_empty   = 2'd0,
        st_loading = 2'd1,
        st_ready   = 2'd2
    } ctrl_state_e;

    // broadcast to every MAC cell
    typedef struct packed {
        logic load_en;
        logic mac_en;
    } pe_ctrl_t;

    // row_idx is the destination row of the weight now on the top edge
    typedef struct packed {
        logic       track_en;
        logic       first_weight;
        logic [7:0] row_idx;
    } track_ctrl_t;

endpackage : systolic_ctrl_pkg

`default_nettype wire

//--- source/systolic_cfg_pkg.sv
`default_nettype none

// array dimensions and data width used by the top level and testbench
package systolic_cfg_pkg;

    // rows of MAC cells, one weight per row ends up in each column
    parameter int DEFAULT_ROWS = 4;

    // columns of MAC cells, one output word per column
    parameter int DEFAULT_COLS = 4;

    // width of weights, activations and partial sums
    parameter int DEFAULT_WORD_SIZE = 16;

endpackage : systolic_cfg_pkg

`default_nettype wire
